//--- logic/vlsu_address_gen.sv
`timescale 1ns/1ps

module vlsu_address_gen
    import vlsu_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  start_i,
    input  vlsu_cfg_t             cfg_i,
    input  logic                  access_i,
    input  logic [ELEM_IDX_W-1:0] elem_idx_i,

    output logic [31:0]           address_o
);

    logic [31:0] offset_q;
    logic [31:0] step;
    logic [31:0] index_offset;
    logic [31:0] offset;

    // Unit-stride steps by the element size in bytes
    assign step = (cfg_i.mode == STRIDED) ? cfg_i.stride : (32'd1 << cfg_i.width);

    // Running offset for both strided modes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset_q <= '0;
        end
        else if (start_i) begin
            offset_q <= '0;
        end
        else if (access_i) begin
            offset_q <= offset_q + step;
        end
    end

    // Index element read at the data element width
    assign index_offset = elem_select(cfg_i.index_vec, elem_idx_i, cfg_i.width);

    assign offset = (cfg_i.mode == INDEXED) ? index_offset : offset_q;

    assign address_o = cfg_i.base + offset;

endmodule

//--- logic/vlsu_bus_pkg.sv
package vlsu_bus_pkg;

    // Data memory port
    localparam int BUS_WIDTH = 32;
    localparam int BUS_LANES = BUS_WIDTH / 8;

    // Address bits that pick a byte lane
    localparam int LANE_W = $clog2(BUS_LANES);

    // One memory request per cycle
    typedef struct packed {
        logic [31:0]          address;
        logic                 read_en;
        logic [BUS_LANES-1:0] write_en;
        logic [BUS_WIDTH-1:0] wdata;
    } mem_req_t;

endpackage

//--- logic/vlsu_cfg_pkg.sv
package vlsu_cfg_pkg;

    // Vector register geometry
    localparam int VLEN       = 64;
    localparam int VLENB      = VLEN / 8;
    localparam int VL_W       = 4;
    localparam int ELEM_IDX_W = 3;
    localparam int VEC_OFF_W  = $clog2(VLEN);

    // Encoded as log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } elem_width_e;

    typedef enum logic [1:0] {
        UNIT_STRIDED = 2'b00,
        INDEXED      = 2'b01,
        STRIDED      = 2'b10
    } addr_mode_e;

    // Request as held for the whole transfer
    typedef struct packed {
        logic              is_store;
        elem_width_e       width;
        addr_mode_e        mode;
        logic              vm;
        logic [VL_W-1:0]   vl;
        logic [31:0]       base;
        logic [31:0]       stride;
        logic [VLENB-1:0]  mask;
        logic [VLEN-1:0]   index_vec;
        logic [VLEN-1:0]   store_vec;
    } vlsu_cfg_t;

    // Bit position of element idx inside a vector register
    function automatic logic [VEC_OFF_W-1:0] elem_bit_offset(
        input logic [ELEM_IDX_W-1:0] idx,
        input elem_width_e           width
    );
        logic [VEC_OFF_W-1:0] off;
        off = {idx, 3'b000};
        return off << width;
    endfunction

    // Element idx of a vector, zero-extended to 32 bits
    function automatic logic [31:0] elem_select(
        input logic [VLEN-1:0]       vec,
        input logic [ELEM_IDX_W-1:0] idx,
        input elem_width_e           width
    );
        logic [VLEN-1:0] shifted;
        shifted = vec >> elem_bit_offset(idx, width);
        unique case (width)
            EW8:     return {24'h0, shifted[7:0]};
            EW16:    return {16'h0, shifted[15:0]};
            default: return shifted[31:0];
        endcase
    endfunction

endpackage

//--- logic/vlsu_config.sv
`timescale 1ns/1ps

module vlsu_config
    import vlsu_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,

    input  logic              start_i,
    input  logic [31:0]       instruction_i,
    input  logic [31:0]       base_address_i,
    input  logic [31:0]       stride_i,
    input  logic [VL_W-1:0]   vl_i,
    input  logic              vm_i,
    input  logic [VLENB-1:0]  mask_i,
    input  logic [VLEN-1:0]   indexed_offsets_i,
    input  logic [VLEN-1:0]   write_data_i,

    output vlsu_cfg_t         cfg_o
);

    elem_width_e width;
    addr_mode_e  mode;
    vlsu_cfg_t   cfg_q;

////////////////////
// Decode
////////////////////

    // Width field, anything other than 8 or 16 bits is taken as 32
    always_comb begin
        unique case (instruction_i[14:12])
            3'b000:  width = EW8;
            3'b101:  width = EW16;
            default: width = EW32;
        endcase
    end

    // Ordered and unordered indexed share one mode
    always_comb begin
        unique case (instruction_i[27:26])
            2'b00:   mode = UNIT_STRIDED;
            2'b10:   mode = STRIDED;
            default: mode = INDEXED;
        endcase
    end

////////////////////
// Request register
////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg_q <= '0;
        end
        else if (start_i) begin
            cfg_q <= '{
                is_store:  instruction_i[5],
                width:     width,
                mode:      mode,
                vm:        vm_i,
                vl:        vl_i,
                base:      base_address_i,
                stride:    stride_i,
                mask:      mask_i,
                index_vec: indexed_offsets_i,
                store_vec: write_data_i
            };
        end
    end

    assign cfg_o = cfg_q;

endmodule

//--- logic/vlsu_load_align.sv
`timescale 1ns/1ps

module vlsu_load_align
    import vlsu_cfg_pkg::*;
    import vlsu_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  start_i,
    input  vlsu_cfg_t             cfg_i,
    input  logic                  access_i,
    input  logic [ELEM_IDX_W-1:0] elem_idx_i,
    input  logic [31:0]           address_i,
    input  logic [BUS_WIDTH-1:0]  mem_rdata_i,

    output logic [VLEN-1:0]       read_data_o
);

    logic                  active_q;
    logic                  keep_q;
    logic [LANE_W-1:0]     lane_q;
    logic [ELEM_IDX_W-1:0] idx_q;

    logic [BUS_WIDTH-1:0]  lane_word;
    logic [31:0]           width_mask;
    logic [VEC_OFF_W-1:0]  bit_off;
    logic [VLEN-1:0]       field_mask;
    logic [VLEN-1:0]       field_data;
    logic [VLEN-1:0]       read_data_q;

////////////////////
// Access stage
////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active_q <= 1'b0;
        end
        else begin
            active_q <= access_i && !cfg_i.is_store;
        end
    end

    always_ff @(posedge clk) begin
        lane_q <= address_i[LANE_W-1:0];
        idx_q  <= elem_idx_i;
        keep_q <= cfg_i.vm || cfg_i.mask[elem_idx_i];
    end

////////////////////
// Data stage
////////////////////

    // Element moved down to lane 0
    assign lane_word = mem_rdata_i >> {lane_q, 3'b000};

    always_comb begin
        unique case (cfg_i.width)
            EW8:     width_mask = 32'h0000_00ff;
            EW16:    width_mask = 32'h0000_ffff;
            default: width_mask = 32'hffff_ffff;
        endcase
    end

    assign bit_off    = elem_bit_offset(idx_q, cfg_i.width);
    assign field_mask = VLEN'(width_mask) << bit_off;

    // Masked-off elements land as zero
    assign field_data = keep_q ? (VLEN'(lane_word & width_mask) << bit_off) : '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_data_q <= '0;
        end
        else if (start_i) begin
            read_data_q <= '0;
        end
        else if (active_q) begin
            read_data_q <= (read_data_q & ~field_mask) | field_data;
        end
    end

    assign read_data_o = read_data_q;

endmodule

//--- logic/vlsu_sequencer.sv
`timescale 1ns/1ps

module vlsu_sequencer
    import vlsu_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    input  logic                  start_i,
    input  vlsu_cfg_t             cfg_i,

    output logic                  access_o,
    output logic [ELEM_IDX_W-1:0] elem_idx_o,
    output logic                  last_o,
    output logic                  busy_o,
    output logic                  done_o
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DRAIN
    } seq_state_e;

    seq_state_e            state, next_state;
    logic [ELEM_IDX_W-1:0] elem_idx_q;
    logic                  tail_q;

////////////////////
// FSM
////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE:
                if (start_i)
                    next_state = ACCESS;
            ACCESS:
                // One cycle without an access closes the element phase
                if (!access_o)
                    next_state = (cfg_i.is_store || cfg_i.vl == '0) ? IDLE : DRAIN;
            DRAIN:
                next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    // One element per access cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            elem_idx_q <= '0;
        end
        else if (start_i && state == IDLE) begin
            elem_idx_q <= '0;
        end
        else if (access_o) begin
            elem_idx_q <= elem_idx_q + 1'b1;
        end
    end

    // High in the cycle after the last access
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tail_q <= 1'b0;
        end
        else begin
            tail_q <= last_o;
        end
    end

////////////////////
// Strobes
////////////////////

    assign access_o   = (state == ACCESS) && (cfg_i.vl != '0) && !tail_q;
    assign last_o     = access_o && (VL_W'(elem_idx_q) == cfg_i.vl - VL_W'(1));
    assign elem_idx_o = elem_idx_q;
    assign busy_o     = (state != IDLE);

    // Loads finish one cycle later, in DRAIN
    assign done_o = ((state == ACCESS) && !access_o && (cfg_i.is_store || cfg_i.vl == '0))
                    || (state == DRAIN);

endmodule

//--- logic/vlsu_store_lanes.sv
`timescale 1ns/1ps

module vlsu_store_lanes
    import vlsu_cfg_pkg::*;
    import vlsu_bus_pkg::*;
(
    input  vlsu_cfg_t             cfg_i,
    input  logic                  access_i,
    input  logic [ELEM_IDX_W-1:0] elem_idx_i,
    input  logic [31:0]           address_i,

    output logic [BUS_LANES-1:0]  write_en_o,
    output logic [BUS_WIDTH-1:0]  wdata_o
);

    logic [31:0]          elem;
    logic [LANE_W-1:0]    lane;
    logic [BUS_LANES-1:0] lane_en;
    logic                 enable;

    assign elem = elem_select(cfg_i.store_vec, elem_idx_i, cfg_i.width);
    assign lane = address_i[LANE_W-1:0];

    // Same element on every lane, memory picks it with the byte enables
    always_comb begin
        unique case (cfg_i.width)
            EW8:     wdata_o = {4{elem[7:0]}};
            EW16:    wdata_o = {2{elem[15:0]}};
            default: wdata_o = elem;
        endcase
    end

    // Aligned addresses keep an element inside one bus word
    always_comb begin
        unique case (cfg_i.width)
            EW8:     lane_en = 4'b0001 << lane;
            EW16:    lane_en = 4'b0011 << {lane[1], 1'b0};
            default: lane_en = 4'b1111;
        endcase
    end

    // Masked-off elements are skipped
    assign enable = access_i && cfg_i.is_store && (cfg_i.vm || cfg_i.mask[elem_idx_i]);

    assign write_en_o = enable ? lane_en : '0;

endmodule

//--- logic/vlsu_top.sv
`timescale 1ns/1ps

module vlsu_top
    import vlsu_cfg_pkg::*;
    import vlsu_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    // Request, sampled with start_i
    input  logic                 start_i,
    input  logic [31:0]          instruction_i,
    input  logic [31:0]          base_address_i,
    input  logic [31:0]          stride_i,
    input  logic [VL_W-1:0]      vl_i,
    input  logic                 vm_i,
    input  logic [VLENB-1:0]     mask_i,
    input  logic [VLEN-1:0]      indexed_offsets_i,
    input  logic [VLEN-1:0]      write_data_i,

    // Memory port
    output mem_req_t             mem_o,
    input  logic [BUS_WIDTH-1:0] mem_rdata_i,

    output logic                 busy_o,
    output logic                 done_o,
    output logic [VLEN-1:0]      read_data_o
);

    vlsu_cfg_t             cfg;
    logic                  start;
    logic                  access;
    logic [ELEM_IDX_W-1:0] elem_idx;
    logic [31:0]           address;
    logic [BUS_LANES-1:0]  write_en;
    logic [BUS_WIDTH-1:0]  wdata;

    // A request is taken only while no transfer runs
    assign start = start_i && !busy_o;

    vlsu_config u_config (
        .clk               (clk),
        .reset_n           (reset_n),
        .start_i           (start),
        .instruction_i     (instruction_i),
        .base_address_i    (base_address_i),
        .stride_i          (stride_i),
        .vl_i              (vl_i),
        .vm_i              (vm_i),
        .mask_i            (mask_i),
        .indexed_offsets_i (indexed_offsets_i),
        .write_data_i      (write_data_i),
        .cfg_o             (cfg)
    );

    // Last-access flag only steers the FSM itself
    vlsu_sequencer u_sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start),
        .cfg_i      (cfg),
        .access_o   (access),
        .elem_idx_o (elem_idx),
        .last_o     (),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    vlsu_address_gen u_address_gen (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start),
        .cfg_i      (cfg),
        .access_i   (access),
        .elem_idx_i (elem_idx),
        .address_o  (address)
    );

    vlsu_store_lanes u_store_lanes (
        .cfg_i      (cfg),
        .access_i   (access),
        .elem_idx_i (elem_idx),
        .address_i  (address),
        .write_en_o (write_en),
        .wdata_o    (wdata)
    );

    vlsu_load_align u_load_align (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start),
        .cfg_i       (cfg),
        .access_i    (access),
        .elem_idx_i  (elem_idx),
        .address_i   (address),
        .mem_rdata_i (mem_rdata_i),
        .read_data_o (read_data_o)
    );

    // Loads read every element, masking is applied on the way back
    assign mem_o = '{
        address:  address,
        read_en:  access && !cfg.is_store,
        write_en: write_en,
        wdata:    wdata
    };

endmodule

//--- src.f
logic/vlsu_cfg_pkg.sv
logic/vlsu_bus_pkg.sv
logic/vlsu_config.sv
logic/vlsu_sequencer.sv
logic/vlsu_address_gen.sv
logic/vlsu_store_lanes.sv
logic/vlsu_load_align.sv
logic/vlsu_top.sv
testbench/vlsu_properties.sv
testbench/tb_vlsu.sv

//--- testbench/tb_vlsu.sv
`timescale 1ns/1ps

module tb_vlsu
    import vlsu_cfg_pkg::*;
    import vlsu_bus_pkg::*;
();

    localparam int NUM_TESTS    = 72;
    localparam int LIMIT_CYCLES = 16 + NUM_TESTS * (VLENB + 4) + 200;

    logic clk = 1'b0;
    logic reset_n = 1'b0;
    logic start_i = 1'b0;
    logic [31:0] instruction_i = '0;
    logic [31:0] base_address_i = '0;
    logic [31:0] stride_i = '0;
    logic [VL_W-1:0] vl_i = '0;
    logic vm_i = 1'b0;
    logic [VLENB-1:0] mask_i = '0;
    logic [VLEN-1:0] indexed_offsets_i = '0;
    logic [VLEN-1:0] write_data_i = '0;
    logic [BUS_WIDTH-1:0] mem_rdata = '0;
    mem_req_t mem_req;
    logic busy_o;
    logic done_o;
    logic [VLEN-1:0] read_data_o;

    logic [7:0] mem [256];
    logic [7:0] exp_mem [256];
    logic [31:0] seed = 32'h36bf;
    logic [31:0] op_base;
    logic [31:0] op_stride;
    logic [VLEN-1:0] op_index;
    logic [VLEN-1:0] exp_read;
    logic [VLEN-1:0] read_at_done;
    logic busy_after_done;
    int exp_cycles;
    int done_cycle;
    int busy_low_cycles;
    int data_errors = 0;
    int timing_errors = 0;
    event check_ev;

    vlsu_top dut0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .start_i           (start_i),
        .instruction_i     (instruction_i),
        .base_address_i    (base_address_i),
        .stride_i          (stride_i),
        .vl_i              (vl_i),
        .vm_i              (vm_i),
        .mask_i            (mask_i),
        .indexed_offsets_i (indexed_offsets_i),
        .write_data_i      (write_data_i),
        .mem_o             (mem_req),
        .mem_rdata_i       (mem_rdata),
        .busy_o            (busy_o),
        .done_o            (done_o),
        .read_data_o       (read_data_o)
    );

    always #4 clk = ~clk;

////////////////////
// Memory model
////////////////////

    // Word read with one cycle latency, byte writes at the clock edge
    always @(posedge clk) begin
        if (mem_req.read_en)
            mem_rdata <= {mem[{mem_req.address[7:2], 2'd3}], mem[{mem_req.address[7:2], 2'd2}],
                          mem[{mem_req.address[7:2], 2'd1}], mem[{mem_req.address[7:2], 2'd0}]};
        for (int b = 0; b < BUS_LANES; b++)
            if (mem_req.write_en[b])
                mem[{mem_req.address[7:2], 2'(b)}] <= mem_req.wdata[8*b +: 8];
    end

////////////////////
// Reference
////////////////////

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Updates exp_mem for stores, returns the expected result vector
    function automatic logic [VLEN-1:0] ref_transfer(
        input logic is_store, input int w, input int mode, input logic vm, input int vl,
        input logic [31:0] base, input logic [31:0] stride, input logic [VLENB-1:0] mask,
        input logic [VLEN-1:0] idx_vec, input logic [VLEN-1:0] wvec
    );
        logic [VLEN-1:0] res;
        logic [31:0] addr;
        int nb;
        res = '0;
        nb = 1 << w;
        for (int i = 0; i < vl; i++) begin
            if (mode == 0)
                addr = base + 32'(i * nb);
            else if (mode == 1)
                addr = base + 32'(i) * stride;
            else
                addr = base + 32'((idx_vec >> (i * 8 * nb)) & ((64'd1 << (8 * nb)) - 64'd1));
            if (vm || mask[i]) begin
                for (int b = 0; b < nb; b++) begin
                    if (is_store)
                        exp_mem[8'(addr + b)] = wvec[i*8*nb + 8*b +: 8];
                    else
                        res[i*8*nb + 8*b +: 8] = exp_mem[8'(addr + b)];
                end
            end
        end
        return res;
    endfunction

////////////////////
// Stimulus
////////////////////

    // Aligned base, stride and index offsets shared by a store and its load
    task automatic pick_operands(input int w);
        op_base   = next_rand() & 32'hffff_fffc;
        op_stride = (next_rand() % 9) << w;
        op_index  = {next_rand(), next_rand()};
        if (w == 1)
            op_index = op_index & 64'hfffe_fffe_fffe_fffe;
        else if (w == 2)
            op_index = op_index & 64'hffff_fffc_ffff_fffc;
    endtask

    task automatic run_transfer(input logic is_store, input int w, input int mode,
                                input logic vm, input int vl);
        logic [VLENB-1:0] mask;
        logic [VLEN-1:0] wvec;
        logic [1:0] mode_bits;
        logic [2:0] width_bits;
        mask = 8'(next_rand());
        wvec = {next_rand(), next_rand()};
        // Both indexed encodings get used
        mode_bits = (mode == 0) ? 2'b00 : (mode == 1) ? 2'b10 : (is_store ? 2'b01 : 2'b11);
        width_bits = (w == 0) ? 3'b000 : (w == 1) ? 3'b101 : 3'b110;
        @(negedge clk);
        exp_read = ref_transfer(is_store, w, mode, vm, vl, op_base, op_stride, mask,
                                op_index, wvec);
        exp_cycles = (vl == 0) ? 1 : (is_store ? vl + 1 : vl + 2);
        start_i = 1'b1;
        instruction_i = {4'h0, mode_bits, 11'h0, width_bits, 6'h0, is_store, 5'b00111};
        base_address_i = op_base;
        stride_i = op_stride;
        vl_i = VL_W'(vl);
        vm_i = vm;
        mask_i = mask;
        indexed_offsets_i = op_index;
        write_data_i = wvec;
        @(negedge clk);
        start_i = 1'b0;
        done_cycle = 1;
        busy_low_cycles = 0;
        while (!done_o) begin
            if (!busy_o)
                busy_low_cycles++;
            @(negedge clk);
            done_cycle++;
        end
        if (!busy_o)
            busy_low_cycles++;
        // Result vector is due in the done cycle itself
        read_at_done = read_data_o;
        @(negedge clk);
        busy_after_done = busy_o;
        -> check_ev;
    endtask

////////////////////
// Checker
////////////////////

    always @(check_ev) begin
        assert (done_cycle == exp_cycles) else begin
            $display("done_o came %0d cycles after start instead of %0d", done_cycle, exp_cycles);
            timing_errors++;
        end
        assert (busy_low_cycles == 0) else begin
            $display("busy_o was low in %0d cycles before done_o", busy_low_cycles);
            timing_errors++;
        end
        assert (!busy_after_done) else begin
            $display("busy_o stayed high after done_o");
            timing_errors++;
        end
        assert (read_at_done == exp_read) else begin
            $display("Mismatch read_data_o at done_o: got %h expected %h",
                     read_at_done, exp_read);
            data_errors++;
        end
        assert (read_data_o == exp_read) else begin
            $display("Mismatch read_data_o: got %h expected %h", read_data_o, exp_read);
            data_errors++;
        end
        for (int a = 0; a < 256; a++)
            assert (mem[a] == exp_mem[a]) else begin
                $display("Mismatch mem[%02h]: got %02h expected %02h", a, mem[a], exp_mem[a]);
                data_errors++;
            end
    end

    initial begin
        #(LIMIT_CYCLES * 8);
        $display("Watchdog expired before all transfers completed");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(a * 7 + 17);
            exp_mem[a] = 8'(a * 7 + 17);
        end
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        // Full, masked, short and empty transfers per width and mode
        for (int w = 0; w < 3; w++)
            for (int m = 0; m < 3; m++)
                for (int k = 0; k < 4; k++) begin
                    pick_operands(w);
                    run_transfer(1'b1, w, m, k == 0 || k == 3,
                                 (k == 3) ? 0 : (VLENB >> w) - (k == 2));
                    run_transfer(1'b0, w, m, k == 0 || k == 3,
                                 (k == 3) ? 0 : (VLENB >> w) - (k == 2));
                end
        @(negedge clk);
        $display("Checks finished with %0d data errors, %0d timing errors, %0d assertion failures",
                 data_errors, timing_errors, dut0.u_props.fail_count);
        if (data_errors + timing_errors + dut0.u_props.fail_count == 0) begin
            $display("TESTS PASSED");
        end
        else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/vlsu_properties.sv
`timescale 1ns/1ps

module vlsu_properties
    import vlsu_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 read_en_i,
    input  logic [BUS_LANES-1:0] write_en_i,
    input  logic                 busy_i,
    input  logic                 done_i
);

    int fail_count = 0;

    // A transfer either reads or writes
    no_read_and_write: assert property (@(posedge clk) disable iff (!reset_n)
        !(read_en_i && (|write_en_i)))
    else begin
        $error("read_en and write_en active together");
        fail_count++;
    end

    // Bus stays quiet outside a transfer
    idle_bus: assert property (@(posedge clk) disable iff (!reset_n)
        !busy_i |-> (!read_en_i && (write_en_i == '0)))
    else begin
        $error("memory enable active while busy_o is low");
        fail_count++;
    end

    single_done: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
    else begin
        $error("done_o high for two cycles in a row");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !busy_i)
    else begin
        $error("busy_o high right after reset release");
        fail_count++;
    end

endmodule

bind vlsu_top vlsu_properties u_props (
    .clk        (clk),
    .reset_n    (reset_n),
    .read_en_i  (mem_o.read_en),
    .write_en_i (mem_o.write_en),
    .busy_i     (busy_o),
    .done_i     (done_o)
);
